/* common/memsys_params.svh */
// Address-space and SRAM-size parameters of the memory subsystem.
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// Byte address width, covering 8 KiB of data memory.
`define MEMSYS_ADDR_W 13

// Number of 64-bit words in the data SRAM.
// This must equal 2**(`MEMSYS_ADDR_W-3).
`define MEMSYS_DEPTH 1024

`endif

/* common/memsys_pkg.sv */
// Shared types of the memory subsystem: memory-op codes, the memory word and arbiter grants.
package memsys_pkg;

  // Size and signedness of a load or store.
  // Stores use the same codes and ignore the signedness.
  typedef enum logic [2:0] {
    MOP_LB   = 3'b000,
    MOP_LBU  = 3'b001,
    MOP_LH   = 3'b010,
    MOP_LHU  = 3'b011,
    MOP_LW   = 3'b100,
    MOP_LWU  = 3'b101,
    MOP_LD   = 3'b110,
    MOP_NONE = 3'b111
  } mem_op_e;

  // One SRAM word.
  // It is seen either as a whole doubleword or as eight byte lanes, lane 0 lowest.
  typedef union packed {
    logic [63:0]     dword;
    logic [7:0][7:0] bytes;
  } mem_word_u;

  // Owner of the SRAM port.
  typedef enum logic [1:0] {
    GNT_NONE = 2'd0,
    GNT_LSU  = 2'd1,
    GNT_IF   = 2'd2
  } arb_grant_e;

endpackage

/* lsu/lsu_align.sv */
// Load/store lane alignment: byte mask, store lane shift, load extract and extension.
`timescale 1ns/1ps
`include "memsys_params.svh"

module lsu_align import memsys_pkg::*; (
  input  mem_op_e                   i_op,
  input  logic [`MEMSYS_ADDR_W-1:0] i_addr,
  input  logic [63:0]               i_wdata,
  input  mem_word_u                 i_rword,
  output logic [7:0]                o_mask,
  output mem_word_u                 o_wword,
  output logic [63:0]               o_rdata,
  output logic                      o_misalign
);

  logic [2:0] offset;
  logic [7:0] size_mask;
  mem_word_u  wsrc;
  mem_word_u  rshift;

  assign offset = i_addr[2:0];

  // Footprint of the access before it is moved to its lane.
  always_comb begin
    case (i_op)
      MOP_LB, MOP_LBU: size_mask = 8'b0000_0001;
      MOP_LH, MOP_LHU: size_mask = 8'b0000_0011;
      MOP_LW, MOP_LWU: size_mask = 8'b0000_1111;
      MOP_LD:          size_mask = 8'b1111_1111;
      default:         size_mask = 8'b0000_0000;
    endcase
  end

  always_comb begin
    case (i_op)
      MOP_LH, MOP_LHU: o_misalign = offset[0];
      MOP_LW, MOP_LWU: o_misalign = |offset[1:0];
      MOP_LD:          o_misalign = |offset;
      default:         o_misalign = 1'b0;
    endcase
  end

  // A misaligned access touches no lanes at all.
  assign o_mask = o_misalign ? 8'h00 : (size_mask << offset);

  // Store data moves up so that its byte 0 lands in lane offset.
  assign wsrc.dword = i_wdata;

  always_comb begin
    o_wword.dword = 64'h0;
    for (int i = 0; i < 8; i++) begin
      if (i >= int'(offset)) begin
        o_wword.bytes[i] = wsrc.bytes[3'(i) - offset];
      end
    end
  end

  // Load data moves down so that lane offset becomes byte 0.
  always_comb begin
    rshift.dword = 64'h0;
    for (int i = 0; i < 8; i++) begin
      if (i + int'(offset) < 8) begin
        rshift.bytes[i] = i_rword.bytes[3'(i) + offset];
      end
    end
  end

  always_comb begin
    case (i_op)
      MOP_LB:  o_rdata = {{56{rshift.bytes[0][7]}}, rshift.bytes[0]};
      MOP_LBU: o_rdata = {56'h0, rshift.bytes[0]};
      MOP_LH:  o_rdata = {{48{rshift.dword[15]}}, rshift.dword[15:0]};
      MOP_LHU: o_rdata = {48'h0, rshift.dword[15:0]};
      MOP_LW:  o_rdata = {{32{rshift.dword[31]}}, rshift.dword[31:0]};
      MOP_LWU: o_rdata = {32'h0, rshift.dword[31:0]};
      MOP_LD:  o_rdata = rshift.dword;
      default: o_rdata = 64'h0;
    endcase
    // Misaligned loads return zero.
    if (o_misalign) begin
      o_rdata = 64'h0;
    end
  end

endmodule

/* lsu/lsu_port.sv */
// Load/store requester between the outer handshake and the SRAM arbiter.
`timescale 1ns/1ps
`include "memsys_params.svh"

module lsu_port import memsys_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_ls_req,
  input  logic                      i_ls_we,
  input  mem_op_e                   i_ls_op,
  input  logic [`MEMSYS_ADDR_W-1:0] i_ls_addr,
  input  logic [63:0]               i_ls_wdata,
  output logic                      o_ls_ack,
  output logic [63:0]               o_ls_rdata,
  output logic                      o_ls_err,
  output logic                      o_mreq,
  output logic                      o_mwe,
  output logic [`MEMSYS_ADDR_W-1:0] o_maddr,
  output logic [7:0]                o_mmask,
  output logic [63:0]               o_mwdata,
  input  logic                      i_mack,
  input  mem_word_u                 i_mrdata
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_ACCESS  = 2'd1;
  localparam logic [1:0] ST_HOLD    = 2'd2;
  localparam logic [1:0] ST_RELEASE = 2'd3;

  logic [1:0]                state;
  logic                      we_q;
  mem_op_e                   op_q;
  logic [`MEMSYS_ADDR_W-1:0] addr_q;
  logic [63:0]               wdata_q;
  mem_op_e                   sel_op;
  logic [`MEMSYS_ADDR_W-1:0] sel_addr;
  logic [63:0]               sel_wdata;
  mem_word_u                 wword;
  logic [63:0]               load_data;
  logic                      misalign;
  logic                      skip;

  // While idle the aligner looks at the live request, so that a request with
  // nothing to do can be answered on the next edge.
  assign sel_op    = (state == ST_IDLE) ? i_ls_op    : op_q;
  assign sel_addr  = (state == ST_IDLE) ? i_ls_addr  : addr_q;
  assign sel_wdata = (state == ST_IDLE) ? i_ls_wdata : wdata_q;
  assign skip      = (sel_op == MOP_NONE) || misalign;

  lsu_align lsu_align_inst (
    .i_op      (sel_op),
    .i_addr    (sel_addr),
    .i_wdata   (sel_wdata),
    .i_rword   (i_mrdata),
    .o_mask    (o_mmask),
    .o_wword   (wword),
    .o_rdata   (load_data),
    .o_misalign(misalign)
  );

  assign o_mwe    = we_q;
  assign o_maddr  = addr_q;
  assign o_mwdata = wword.dword;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      o_mreq   <= 1'b0;
      o_ls_ack <= 1'b0;
      o_ls_err <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_ls_req && skip) begin
            o_ls_ack <= 1'b1;
            o_ls_err <= misalign;
            state    <= ST_HOLD;
          end else if (i_ls_req) begin
            o_mreq <= 1'b1;
            state  <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          if (i_mack) begin
            o_mreq   <= 1'b0;
            o_ls_ack <= 1'b1;
            state    <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (!i_ls_req) begin
            o_ls_ack <= 1'b0;
            o_ls_err <= 1'b0;
            state    <= ST_RELEASE;
          end
        end
        default: begin
          // Wait for the arbiter to finish its side of the handshake.
          if (!i_mack) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_ls_req) begin
      we_q       <= i_ls_we;
      op_q       <= i_ls_op;
      addr_q     <= i_ls_addr;
      wdata_q    <= i_ls_wdata;
      o_ls_rdata <= 64'h0;
    end
    // Stores keep the zero result.
    if (state == ST_ACCESS && i_mack && !we_q) begin
      o_ls_rdata <= load_data;
    end
  end

endmodule

/* hdl/ifetch_port.sv */
// Instruction-fetch requester that reads one 32-bit instruction through the SRAM arbiter.
`timescale 1ns/1ps
`include "memsys_params.svh"

module ifetch_port (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_if_req,
  input  logic [`MEMSYS_ADDR_W-1:0] i_if_addr,
  output logic                      o_if_ack,
  output logic [31:0]               o_if_instr,
  output logic                      o_if_err,
  output logic                      o_mreq,
  output logic [`MEMSYS_ADDR_W-1:0] o_maddr,
  input  logic                      i_mack,
  input  logic [63:0]               i_mrdata
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_ACCESS  = 2'd1;
  localparam logic [1:0] ST_HOLD    = 2'd2;
  localparam logic [1:0] ST_RELEASE = 2'd3;

  logic [1:0]                state;
  logic [`MEMSYS_ADDR_W-1:0] addr_q;

  assign o_maddr = addr_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      o_mreq   <= 1'b0;
      o_if_ack <= 1'b0;
      o_if_err <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Unaligned fetches are refused without touching memory.
          if (i_if_req && |i_if_addr[1:0]) begin
            o_if_ack <= 1'b1;
            o_if_err <= 1'b1;
            state    <= ST_HOLD;
          end else if (i_if_req) begin
            o_mreq <= 1'b1;
            state  <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          if (i_mack) begin
            o_mreq   <= 1'b0;
            o_if_ack <= 1'b1;
            state    <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (!i_if_req) begin
            o_if_ack <= 1'b0;
            o_if_err <= 1'b0;
            state    <= ST_RELEASE;
          end
        end
        default: begin
          if (!i_mack) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_if_req) begin
      addr_q     <= i_if_addr;
      o_if_instr <= 32'h0;
    end
    // Address bit 2 picks the upper instruction of the doubleword.
    if (state == ST_ACCESS && i_mack) begin
      o_if_instr <= addr_q[2] ? i_mrdata[63:32] : i_mrdata[31:0];
    end
  end

endmodule

/* hdl/mem_arbiter.sv */
// Round-robin arbiter that shares the data SRAM between the load/store and fetch ports.
`timescale 1ns/1ps
`include "memsys_params.svh"

module mem_arbiter import memsys_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_lsu_req,
  input  logic                      i_lsu_we,
  input  logic [`MEMSYS_ADDR_W-1:0] i_lsu_addr,
  input  logic [7:0]                i_lsu_mask,
  input  logic [63:0]               i_lsu_wdata,
  output logic                      o_lsu_ack,
  input  logic                      i_if_req,
  input  logic [`MEMSYS_ADDR_W-1:0] i_if_addr,
  output logic                      o_if_ack,
  output logic                      o_ce,
  output logic                      o_we,
  output logic [`MEMSYS_ADDR_W-4:0] o_index,
  output logic [7:0]                o_mask,
  output logic [63:0]               o_wdata
);

  arb_grant_e grant;
  logic       issued;
  logic       prio_if;
  logic       gnt_lsu;
  logic       gnt_if;
  logic       cur_req;
  logic       cur_ack;

  assign gnt_lsu = (grant == GNT_LSU);
  assign gnt_if  = (grant == GNT_IF);
  assign cur_req = gnt_lsu ? i_lsu_req : i_if_req;
  assign cur_ack = o_lsu_ack || o_if_ack;

  // The SRAM is strobed in the single cycle after a grant is taken.
  assign o_ce    = (gnt_lsu || gnt_if) && !issued;
  assign o_we    = o_ce && gnt_lsu && i_lsu_we;
  assign o_index = gnt_if ? i_if_addr[`MEMSYS_ADDR_W-1:3] : i_lsu_addr[`MEMSYS_ADDR_W-1:3];
  assign o_mask  = gnt_lsu ? i_lsu_mask : 8'h00;
  assign o_wdata = i_lsu_wdata;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      grant     <= GNT_NONE;
      issued    <= 1'b0;
      prio_if   <= 1'b0;
      o_lsu_ack <= 1'b0;
      o_if_ack  <= 1'b0;
    end else begin
      case (grant)
        GNT_NONE: begin
          issued <= 1'b0;
          // prio_if favours the port that was not served last.
          if (i_lsu_req && !(i_if_req && prio_if)) begin
            grant   <= GNT_LSU;
            prio_if <= 1'b1;
          end else if (i_if_req) begin
            grant   <= GNT_IF;
            prio_if <= 1'b0;
          end
        end
        default: begin
          if (!issued) begin
            issued    <= 1'b1;
            o_lsu_ack <= gnt_lsu;
            o_if_ack  <= gnt_if;
          end else if (!cur_req && cur_ack) begin
            o_lsu_ack <= 1'b0;
            o_if_ack  <= 1'b0;
          end else if (!cur_req) begin
            // Both handshake phases are done, so the SRAM is free again.
            grant <= GNT_NONE;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/data_sram.sv */
// Doubleword data SRAM with a byte write mask and a registered read port.
`timescale 1ns/1ps
`include "memsys_params.svh"

module data_sram import memsys_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_ce,
  input  logic                      i_we,
  input  logic [`MEMSYS_ADDR_W-4:0] i_index,
  input  logic [7:0]                i_mask,
  input  mem_word_u                 i_wdata,
  output mem_word_u                 o_rdata
);

  mem_word_u mem [`MEMSYS_DEPTH];

  // Every enabled cycle reads; on a write the old word comes back.
  always_ff @(posedge i_clk) begin
    if (i_ce) begin
      o_rdata <= mem[i_index];
      if (i_we) begin
        for (int b = 0; b < 8; b++) begin
          if (i_mask[b]) begin
            mem[i_index].bytes[b] <= i_wdata.bytes[b];
          end
        end
      end
    end
  end

endmodule

/* hdl/memsys_top.sv */
// Memory subsystem top: load/store and fetch ports sharing one data SRAM through an arbiter.
`timescale 1ns/1ps
`include "memsys_params.svh"

module memsys_top import memsys_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_ls_req,
  input  logic                      i_ls_we,
  input  mem_op_e                   i_ls_op,
  input  logic [`MEMSYS_ADDR_W-1:0] i_ls_addr,
  input  logic [63:0]               i_ls_wdata,
  output logic                      o_ls_ack,
  output logic [63:0]               o_ls_rdata,
  output logic                      o_ls_err,
  input  logic                      i_if_req,
  input  logic [`MEMSYS_ADDR_W-1:0] i_if_addr,
  output logic                      o_if_ack,
  output logic [31:0]               o_if_instr,
  output logic                      o_if_err
);

  logic                      lsu_mreq;
  logic                      lsu_mack;
  logic                      lsu_mwe;
  logic [`MEMSYS_ADDR_W-1:0] lsu_maddr;
  logic [7:0]                lsu_mmask;
  logic [63:0]               lsu_mwdata;
  logic                      if_mreq;
  logic                      if_mack;
  logic [`MEMSYS_ADDR_W-1:0] if_maddr;
  logic                      sram_ce;
  logic                      sram_we;
  logic [`MEMSYS_ADDR_W-4:0] sram_index;
  logic [7:0]                sram_mask;
  logic [63:0]               sram_wdata;
  mem_word_u                 sram_rdata;

  lsu_port lsu_port_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ls_req  (i_ls_req),
    .i_ls_we   (i_ls_we),
    .i_ls_op   (i_ls_op),
    .i_ls_addr (i_ls_addr),
    .i_ls_wdata(i_ls_wdata),
    .o_ls_ack  (o_ls_ack),
    .o_ls_rdata(o_ls_rdata),
    .o_ls_err  (o_ls_err),
    .o_mreq    (lsu_mreq),
    .o_mwe     (lsu_mwe),
    .o_maddr   (lsu_maddr),
    .o_mmask   (lsu_mmask),
    .o_mwdata  (lsu_mwdata),
    .i_mack    (lsu_mack),
    .i_mrdata  (sram_rdata)
  );

  ifetch_port ifetch_port_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_if_req  (i_if_req),
    .i_if_addr (i_if_addr),
    .o_if_ack  (o_if_ack),
    .o_if_instr(o_if_instr),
    .o_if_err  (o_if_err),
    .o_mreq    (if_mreq),
    .o_maddr   (if_maddr),
    .i_mack    (if_mack),
    .i_mrdata  (sram_rdata.dword)
  );

  mem_arbiter mem_arbiter_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_lsu_req  (lsu_mreq),
    .i_lsu_we   (lsu_mwe),
    .i_lsu_addr (lsu_maddr),
    .i_lsu_mask (lsu_mmask),
    .i_lsu_wdata(lsu_mwdata),
    .o_lsu_ack  (lsu_mack),
    .i_if_req   (if_mreq),
    .i_if_addr  (if_maddr),
    .o_if_ack   (if_mack),
    .o_ce       (sram_ce),
    .o_we       (sram_we),
    .o_index    (sram_index),
    .o_mask     (sram_mask),
    .o_wdata    (sram_wdata)
  );

  data_sram data_sram_inst (
    .i_clk  (i_clk),
    .i_ce   (sram_ce),
    .i_we   (sram_we),
    .i_index(sram_index),
    .i_mask (sram_mask),
    .i_wdata(sram_wdata),
    .o_rdata(sram_rdata)
  );

endmodule

/* testbench/memsys_tb.sv */
// Testbench for the memory subsystem with table-driven loads and stores and a random fetch stream.
`timescale 1ns/1ps
`include "memsys_params.svh"

module memsys_tb import memsys_pkg::*; ();

  localparam int AW          = `MEMSYS_ADDR_W;
  localparam int MODEL_BYTES = `MEMSYS_DEPTH * 8;
  localparam int INIT_WORDS  = 32;

  typedef struct packed {
    logic          we;
    mem_op_e       op;
    logic [AW-1:0] addr;
    logic [63:0]   wdata;
    logic [63:0]   exp_rdata;
    logic          exp_err;
  } ls_entry_t;

  logic          i_clk;
  logic          i_rst;
  logic          i_ls_req;
  logic          i_ls_we;
  mem_op_e       i_ls_op;
  logic [AW-1:0] i_ls_addr;
  logic [63:0]   i_ls_wdata;
  logic          o_ls_ack;
  logic [63:0]   o_ls_rdata;
  logic          o_ls_err;
  logic          i_if_req;
  logic [AW-1:0] i_if_addr;
  logic          o_if_ack;
  logic [31:0]   o_if_instr;
  logic          o_if_err;

  logic [7:0]    mem_model [0:MODEL_BYTES-1];
  ls_entry_t     ls_table [$];
  logic [31:0]   lcg_state = 32'hc43f_1b25;
  logic [AW-1:0] last_store_addr = AW'('h80);
  logic          ls_done = 1'b0;
  int            ls_errors = 0;
  int            if_errors = 0;
  int            hs_errors = 0;
  int            fetch_count = 0;
  int            cycle_count = 0;
  int            cycle_limit = 0;

  memsys_top memsys_top_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ls_req  (i_ls_req),
    .i_ls_we   (i_ls_we),
    .i_ls_op   (i_ls_op),
    .i_ls_addr (i_ls_addr),
    .i_ls_wdata(i_ls_wdata),
    .o_ls_ack  (o_ls_ack),
    .o_ls_rdata(o_ls_rdata),
    .o_ls_err  (o_ls_err),
    .i_if_req  (i_if_req),
    .i_if_addr (i_if_addr),
    .o_if_ack  (o_if_ack),
    .o_if_instr(o_if_instr),
    .o_if_err  (o_if_err)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic int op_size(input mem_op_e op);
    case (op)
      MOP_LB, MOP_LBU: return 1;
      MOP_LH, MOP_LHU: return 2;
      MOP_LW, MOP_LWU: return 4;
      MOP_LD:          return 8;
      default:         return 0;
    endcase
  endfunction

  function automatic logic op_signed(input mem_op_e op);
    return (op == MOP_LB) || (op == MOP_LH) || (op == MOP_LW);
  endfunction

  function automatic logic misaligned(input mem_op_e op, input logic [AW-1:0] addr);
    int size;
    size = op_size(op);
    if (size == 0) begin
      return 1'b0;
    end
    return (int'(addr[2:0]) % size) != 0;
  endfunction

  // Reads the model little-endian and extends the value to 64 bits.
  function automatic logic [63:0] model_load(input mem_op_e op, input logic [AW-1:0] addr);
    logic [63:0] val;
    int          size;
    size = op_size(op);
    val  = 64'h0;
    for (int k = 0; k < size; k++) begin
      val[8*k +: 8] = mem_model[addr + AW'(k)];
    end
    if (size > 0 && size < 8 && op_signed(op) && val[8*size-1]) begin
      val = val | (~64'h0 << (8 * size));
    end
    return val;
  endfunction

  function automatic void model_store(input mem_op_e op, input logic [AW-1:0] addr,
                                      input logic [63:0] wdata);
    for (int k = 0; k < op_size(op); k++) begin
      mem_model[addr + AW'(k)] = wdata[8*k +: 8];
    end
  endfunction

  function automatic logic [7:0] fill_byte(input logic [AW-1:0] a);
    return 8'(a * 37) ^ 8'(a >> 8) ^ 8'h5a;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic void add_entry(input logic we, input mem_op_e op, input int addr,
                                    input logic [63:0] wdata, input logic [63:0] exp_rdata,
                                    input logic exp_err);
    ls_entry_t e;
    e.we        = we;
    e.op        = op;
    e.addr      = AW'(addr);
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    ls_table.push_back(e);
  endfunction

  task automatic show_mismatch(input string sig, input logic [63:0] exp, input logic [63:0] got);
    $display("[FAIL] time %0t: %s expected 0x%h got 0x%h", $time, sig, exp, got);
  endtask

  task automatic build_table();
    // Each entry lists we, op, addr, wdata, expected rdata and expected err.
    add_entry(1'b1, MOP_LD,   'h80, 64'h0123_4567_89ab_cdef, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h80, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0);
    add_entry(1'b1, MOP_LB,   'h88, 64'hdead_beef_cafe_0011, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LB,   'h89, 64'hdead_beef_cafe_0092, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LBU,  'h8a, 64'hdead_beef_cafe_0033, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LB,   'h8b, 64'hdead_beef_cafe_00b4, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LB,   'h8c, 64'hdead_beef_cafe_0055, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LBU,  'h8d, 64'hdead_beef_cafe_00d6, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LB,   'h8e, 64'hdead_beef_cafe_0077, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LB,   'h8f, 64'hdead_beef_cafe_00f8, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h88, 64'h0, 64'hf877_d655_b433_9211, 1'b0);
    add_entry(1'b0, MOP_LB,   'h89, 64'h0, 64'hffff_ffff_ffff_ff92, 1'b0);
    add_entry(1'b0, MOP_LBU,  'h8f, 64'h0, 64'h0000_0000_0000_00f8, 1'b0);
    add_entry(1'b0, MOP_LB,   'h8c, 64'h0, 64'h0000_0000_0000_0055, 1'b0);
    add_entry(1'b1, MOP_LH,   'h90, 64'hcccc_cccc_cccc_8001, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LHU,  'h92, 64'hcccc_cccc_cccc_7ffe, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LH,   'h94, 64'hcccc_cccc_cccc_a5a5, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LH,   'h96, 64'hcccc_cccc_cccc_1234, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h90, 64'h0, 64'h1234_a5a5_7ffe_8001, 1'b0);
    add_entry(1'b0, MOP_LH,   'h90, 64'h0, 64'hffff_ffff_ffff_8001, 1'b0);
    add_entry(1'b0, MOP_LHU,  'h94, 64'h0, 64'h0000_0000_0000_a5a5, 1'b0);
    add_entry(1'b0, MOP_LH,   'h92, 64'h0, 64'h0000_0000_0000_7ffe, 1'b0);
    add_entry(1'b1, MOP_LW,   'h98, 64'h5555_5555_8765_4321, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LWU,  'h9c, 64'h6666_6666_1357_9bdf, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h98, 64'h0, 64'h1357_9bdf_8765_4321, 1'b0);
    add_entry(1'b0, MOP_LW,   'h98, 64'h0, 64'hffff_ffff_8765_4321, 1'b0);
    add_entry(1'b0, MOP_LWU,  'h98, 64'h0, 64'h0000_0000_8765_4321, 1'b0);
    add_entry(1'b0, MOP_LW,   'h9c, 64'h0, 64'h0000_0000_1357_9bdf, 1'b0);
    // Misaligned requests must leave the doubleword at 0x80 alone.
    add_entry(1'b1, MOP_LH,   'h81, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_entry(1'b1, MOP_LW,   'h82, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_entry(1'b1, MOP_LD,   'h84, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1);
    add_entry(1'b0, MOP_LD,   'h83, 64'h0, 64'h0, 1'b1);
    add_entry(1'b0, MOP_LW,   'h86, 64'h0, 64'h0, 1'b1);
    add_entry(1'b0, MOP_LD,   'h80, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0);
    add_entry(1'b1, MOP_NONE, 'h88, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b0);
    add_entry(1'b0, MOP_NONE, 'h88, 64'h0, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h88, 64'h0, 64'hf877_d655_b433_9211, 1'b0);
    // Narrow stores inside a known doubleword must keep the lanes on both sides.
    add_entry(1'b1, MOP_LBU,  'h83, 64'hdead_beef_cafe_00aa, 64'h0, 1'b0);
    add_entry(1'b1, MOP_LHU,  'h84, 64'hcccc_cccc_cccc_5678, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h80, 64'h0, 64'h0123_5678_aaab_cdef, 1'b0);
    add_entry(1'b1, MOP_LW,   'h80, 64'h5555_5555_0bad_f00d, 64'h0, 1'b0);
    add_entry(1'b0, MOP_LD,   'h80, 64'h0, 64'h0123_5678_0bad_f00d, 1'b0);
  endtask

  task automatic run_ls(input ls_entry_t e);
    logic [63:0] got_rdata;
    logic        got_err;
    logic [63:0] model_rdata;
    logic        model_err;
    @(posedge i_clk);
    i_ls_req   <= 1'b1;
    i_ls_we    <= e.we;
    i_ls_op    <= e.op;
    i_ls_addr  <= e.addr;
    i_ls_wdata <= e.wdata;
    @(negedge i_clk);
    while (!o_ls_ack) begin
      @(negedge i_clk);
    end
    got_rdata = o_ls_rdata;
    got_err   = o_ls_err;
    // The model changes at the ack, so a fetch that completes later sees the store.
    model_err   = misaligned(e.op, e.addr);
    model_rdata = 64'h0;
    if (!model_err && !e.we) begin
      model_rdata = model_load(e.op, e.addr);
    end
    if (!model_err && e.we && e.op != MOP_NONE) begin
      model_store(e.op, e.addr, e.wdata);
      last_store_addr = e.addr;
    end
    if (got_rdata !== e.exp_rdata) begin
      show_mismatch("o_ls_rdata", e.exp_rdata, got_rdata);
      ls_errors++;
    end
    if (got_rdata !== model_rdata) begin
      show_mismatch("o_ls_rdata against model", model_rdata, got_rdata);
      ls_errors++;
    end
    if (got_err !== e.exp_err) begin
      show_mismatch("o_ls_err", 64'(e.exp_err), 64'(got_err));
      ls_errors++;
    end
    if (got_err !== model_err) begin
      show_mismatch("o_ls_err against model", 64'(model_err), 64'(got_err));
      ls_errors++;
    end
    repeat (2) begin
      @(negedge i_clk);
      if (o_ls_ack !== 1'b1) begin
        $display("Load/store ack fell at %0t while its request was still high", $time);
        hs_errors++;
      end
      if (o_ls_rdata !== got_rdata || o_ls_err !== got_err) begin
        $display("Load/store result changed at %0t while the ack was high", $time);
        hs_errors++;
      end
    end
    @(posedge i_clk);
    i_ls_req <= 1'b0;
    @(negedge i_clk);
    while (o_ls_ack) begin
      @(negedge i_clk);
    end
  endtask

  task automatic run_fetch(input logic [AW-1:0] addr);
    logic [31:0] exp_instr;
    logic        exp_err;
    @(posedge i_clk);
    i_if_req  <= 1'b1;
    i_if_addr <= addr;
    @(negedge i_clk);
    while (!o_if_ack) begin
      @(negedge i_clk);
    end
    exp_err = |addr[1:0];
    for (int k = 0; k < 4; k++) begin
      exp_instr[8*k +: 8] = mem_model[addr + AW'(k)];
    end
    if (o_if_err !== exp_err) begin
      show_mismatch("o_if_err", 64'(exp_err), 64'(o_if_err));
      if_errors++;
    end
    if (!exp_err && o_if_instr !== exp_instr) begin
      show_mismatch("o_if_instr", 64'(exp_instr), 64'(o_if_instr));
      if_errors++;
    end
    @(negedge i_clk);
    if (o_if_ack !== 1'b1) begin
      $display("Fetch ack fell at %0t while its request was still high", $time);
      hs_errors++;
    end
    @(posedge i_clk);
    i_if_req <= 1'b0;
    @(negedge i_clk);
    while (o_if_ack) begin
      @(negedge i_clk);
    end
    fetch_count++;
  endtask

  task automatic fill_memory();
    ls_entry_t e;
    for (int w = 0; w < INIT_WORDS; w++) begin
      e.we        = 1'b1;
      e.op        = MOP_LD;
      e.addr      = AW'(w * 8);
      e.exp_rdata = 64'h0;
      e.exp_err   = 1'b0;
      for (int k = 0; k < 8; k++) begin
        e.wdata[8*k +: 8] = fill_byte(AW'(w * 8 + k));
      end
      run_ls(e);
    end
  endtask

  task automatic run_table();
    foreach (ls_table[i]) begin
      run_ls(ls_table[i]);
    end
    ls_done = 1'b1;
  endtask

  task automatic run_fetches();
    logic [31:0]   r;
    logic [AW-1:0] addr;
    while (!ls_done) begin
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state;
      addr      = AW'({r[27:22], 2'b00});
      // Every fourth fetch hits the doubleword of the latest store.
      if (fetch_count % 4 == 1) begin
        addr = {last_store_addr[AW-1:2], 2'b00};
      end
      if (fetch_count % 8 == 7) begin
        addr[1:0] = r[21:20] | 2'b01;
      end
      repeat (int'(r[31:30])) @(posedge i_clk);
      run_fetch(addr);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d load/store errors, %0d fetch errors, %0d handshake errors, %0d fetches",
             ls_errors, if_errors, hs_errors, fetch_count);
    if (ls_errors + if_errors + hs_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    @(posedge i_clk);
    while (cycle_count < cycle_limit) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    hs_errors++;
    finish_run();
  end

  initial begin
    i_rst      <= 1'b1;
    i_ls_req   <= 1'b0;
    i_ls_we    <= 1'b0;
    i_ls_op    <= MOP_NONE;
    i_ls_addr  <= '0;
    i_ls_wdata <= 64'h0;
    i_if_req   <= 1'b0;
    i_if_addr  <= '0;
    build_table();
    cycle_limit = 40 * (ls_table.size() + INIT_WORDS) + 400;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    if (o_ls_ack !== 1'b0) begin
      show_mismatch("o_ls_ack after reset", 64'h0, 64'(o_ls_ack));
      hs_errors++;
    end
    if (o_if_ack !== 1'b0) begin
      show_mismatch("o_if_ack after reset", 64'h0, 64'(o_if_ack));
      hs_errors++;
    end
    fill_memory();
    fork
      run_table();
      run_fetches();
    join
    if (fetch_count == 0) begin
      $display("No fetch completed while the load/store table ran");
      if_errors++;
    end
    finish_run();
  end

endmodule

/* memsys_top.f */
+incdir+common
common/memsys_pkg.sv
lsu/lsu_align.sv
lsu/lsu_port.sv
hdl/ifetch_port.sv
hdl/mem_arbiter.sv
hdl/data_sram.sv
hdl/memsys_top.sv
testbench/memsys_tb.sv

/* Makefile */
# Verilator flow for the memory subsystem and its testbench.

VERILATOR ?= verilator
TB_TOP    ?= memsys_tb
RTL_TOP   ?= memsys_top
FILELIST  ?= memsys_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
